// ==== source/rv_core_pkg.sv ====
package rv_core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [6:0]  opcode_t;

  localparam int NUM_REGS   = 32;
  localparam int INSN_BYTES = 4;

  // major opcodes
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_OP     = 7'b0110011;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    // branch compares, result is 1 or 0
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_IMM,
    WB_MEM,
    WB_PC4
  } wb_sel_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_DECODE,
    ST_EXECUTE,
    ST_MEMORY,
    ST_WRITEBACK
  } core_state_e;

endpackage

// ==== source/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode import rv_core_pkg::*; (
  input  logic        CLK,
  input  logic        RST_N,
  input  core_state_e i_state,
  input  word_t       i_insn,
  output reg_addr_t   o_rd,
  output reg_addr_t   o_rs1,
  output reg_addr_t   o_rs2,
  output word_t       o_imm,
  output alu_op_e     o_alu_op,
  output logic        o_use_imm,
  output wb_sel_e     o_wb_sel,
  output logic        o_rd_we,
  output logic        o_is_store,
  output logic        o_is_branch,
  output logic        o_is_jal,
  output logic        o_is_jalr
);

  opcode_t opcode;
  logic [2:0] funct3;
  word_t imm_i, imm_s, imm_b, imm_u, imm_j;
  word_t imm_d;
  alu_op_e alu_op_d;
  logic use_imm_d, rd_we_d, is_store_d, is_branch_d, is_jal_d, is_jalr_d;
  wb_sel_e wb_sel_d;

  // shared by OP and OP-IMM, alt selects SUB or SRA
  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  arith_op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  endfunction

  function automatic alu_op_e branch_op(input logic [2:0] f3);
    case (f3)
      3'b001:  branch_op = ALU_NE;
      3'b100:  branch_op = ALU_LT;
      3'b101:  branch_op = ALU_GE;
      3'b110:  branch_op = ALU_LTU;
      3'b111:  branch_op = ALU_GEU;
      default: branch_op = ALU_EQ;
    endcase
  endfunction

  assign opcode = i_insn[6:0];
  assign funct3 = i_insn[14:12];

  assign imm_i = {{20{i_insn[31]}}, i_insn[31:20]};
  assign imm_s = {{20{i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
  assign imm_b = {{19{i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
  assign imm_u = {i_insn[31:12], 12'b0};
  assign imm_j = {{11{i_insn[31]}}, i_insn[31], i_insn[19:12], i_insn[20],
                  i_insn[30:21], 1'b0};

  always_comb begin
    imm_d       = imm_i;
    alu_op_d    = ALU_ADD;
    use_imm_d   = 1'b1;
    wb_sel_d    = WB_ALU;
    rd_we_d     = 1'b0;
    is_store_d  = 1'b0;
    is_branch_d = 1'b0;
    is_jal_d    = 1'b0;
    is_jalr_d   = 1'b0;
    case (opcode)
      OPC_LUI: begin
        imm_d    = imm_u;
        wb_sel_d = WB_IMM;
        rd_we_d  = 1'b1;
      end
      OPC_JAL: begin
        imm_d    = imm_j;
        wb_sel_d = WB_PC4;
        rd_we_d  = 1'b1;
        is_jal_d = 1'b1;
      end
      OPC_JALR: begin
        wb_sel_d  = WB_PC4;
        rd_we_d   = 1'b1;
        is_jalr_d = 1'b1;
      end
      OPC_BRANCH: begin
        imm_d       = imm_b;
        alu_op_d    = branch_op(funct3);
        use_imm_d   = 1'b0;
        is_branch_d = 1'b1;
      end
      OPC_LOAD: begin
        wb_sel_d = WB_MEM;
        rd_we_d  = 1'b1;
      end
      OPC_STORE: begin
        imm_d      = imm_s;
        is_store_d = 1'b1;
      end
      OPC_OP_IMM: begin
        // shamt sits in imm[4:0], only srai carries bit 30
        alu_op_d = arith_op(funct3, (funct3 == 3'b101) && i_insn[30]);
        rd_we_d  = 1'b1;
      end
      OPC_OP: begin
        alu_op_d  = arith_op(funct3, i_insn[30]);
        use_imm_d = 1'b0;
        rd_we_d   = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      o_alu_op    <= ALU_ADD;
      o_use_imm   <= 1'b0;
      o_wb_sel    <= WB_ALU;
      o_rd_we     <= 1'b0;
      o_is_store  <= 1'b0;
      o_is_branch <= 1'b0;
      o_is_jal    <= 1'b0;
      o_is_jalr   <= 1'b0;
    end else if (i_state == ST_DECODE) begin
      o_alu_op    <= alu_op_d;
      o_use_imm   <= use_imm_d;
      o_wb_sel    <= wb_sel_d;
      o_rd_we     <= rd_we_d;
      o_is_store  <= is_store_d;
      o_is_branch <= is_branch_d;
      o_is_jal    <= is_jal_d;
      o_is_jalr   <= is_jalr_d;
    end
  end

  // register numbers and immediate
  always_ff @(posedge CLK) begin
    if (i_state == ST_DECODE) begin
      o_rd  <= i_insn[11:7];
      o_rs1 <= i_insn[19:15];
      o_rs2 <= i_insn[24:20];
      o_imm <= imm_d;
    end
  end

endmodule

// ==== source/rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu import rv_core_pkg::*; (
  input  logic    CLK,
  input  logic    RST_N,
  input  alu_op_e i_op,
  input  word_t   i_a,
  input  word_t   i_b,
  output word_t   o_result
);

  logic [4:0] shamt;
  logic lt_s, lt_u, eq;
  word_t result_d;

  assign shamt = i_b[4:0];
  assign lt_s  = $signed(i_a) < $signed(i_b);
  assign lt_u  = i_a < i_b;
  assign eq    = i_a == i_b;

  always_comb begin
    case (i_op)
      ALU_ADD:  result_d = i_a + i_b;
      ALU_SUB:  result_d = i_a - i_b;
      ALU_AND:  result_d = i_a & i_b;
      ALU_OR:   result_d = i_a | i_b;
      ALU_XOR:  result_d = i_a ^ i_b;
      ALU_SLL:  result_d = i_a << shamt;
      ALU_SRL:  result_d = i_a >> shamt;
      ALU_SRA:  result_d = word_t'($signed(i_a) >>> shamt);
      ALU_SLT:  result_d = {31'b0, lt_s};
      ALU_SLTU: result_d = {31'b0, lt_u};
      // branch conditions
      ALU_EQ:   result_d = {31'b0, eq};
      ALU_NE:   result_d = {31'b0, !eq};
      ALU_LT:   result_d = {31'b0, lt_s};
      ALU_GE:   result_d = {31'b0, !lt_s};
      ALU_LTU:  result_d = {31'b0, lt_u};
      ALU_GEU:  result_d = {31'b0, !lt_u};
      default:  result_d = '0;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      o_result <= '0;
    end else begin
      o_result <= result_d;
    end
  end

endmodule

// ==== source/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile import rv_core_pkg::*; (
  input  logic      CLK,
  input  logic      RST_N,
  input  reg_addr_t i_rs1,
  input  reg_addr_t i_rs2,
  input  reg_addr_t i_rd,
  input  logic      i_we,
  input  word_t     i_wdata,
  output word_t     o_rs1_data,
  output word_t     o_rs2_data
);

  word_t regs [NUM_REGS];

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_rd != '0)) begin
      // x0 is never written
      regs[i_rd] <= i_wdata;
    end
  end

  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// ==== source/rv_sequencer.sv ====
`timescale 1ns/1ps

module rv_sequencer import rv_core_pkg::*; (
  input  logic        CLK,
  input  logic        RST_N,
  input  logic        i_is_branch,
  input  logic        i_is_jal,
  input  logic        i_is_jalr,
  input  logic        i_taken,
  input  word_t       i_rs1_data,
  input  word_t       i_imm,
  output core_state_e o_state,
  output word_t       o_pc,
  output word_t       o_pc_plus4,
  output word_t       o_imem_addr
);

  core_state_e state_next;
  word_t next_pc;
  word_t seq_pc;

  always_comb begin
    case (o_state)
      ST_IDLE:      state_next = ST_FETCH;
      ST_FETCH:     state_next = ST_DECODE;
      ST_DECODE:    state_next = ST_EXECUTE;
      ST_EXECUTE:   state_next = ST_MEMORY;
      ST_MEMORY:    state_next = ST_WRITEBACK;
      ST_WRITEBACK: state_next = ST_FETCH;
      default:      state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      o_state <= ST_IDLE;
    end else begin
      o_state <= state_next;
    end
  end

  assign seq_pc = o_pc + INSN_BYTES;

  always_comb begin
    if (i_is_jal || (i_is_branch && i_taken)) begin
      next_pc = o_pc + i_imm;
    end else if (i_is_jalr) begin
      next_pc = (i_rs1_data + i_imm) & ~word_t'(1);
    end else begin
      next_pc = seq_pc;
    end
  end

  // pc_plus4 keeps the link of the retiring instruction through writeback
  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      o_pc       <= '0;
      o_pc_plus4 <= '0;
    end else if (o_state == ST_MEMORY) begin
      o_pc       <= next_pc;
      o_pc_plus4 <= seq_pc;
    end
  end

  // instruction memory is word addressed
  assign o_imem_addr = o_pc >> $clog2(INSN_BYTES);

endmodule

// ==== source/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top import rv_core_pkg::*; (
  input  logic  CLK,
  input  logic  RST_N,
  input  word_t i_imem_data,
  input  word_t i_mem_data,
  output word_t o_imem_addr,
  output word_t o_mem_addr,
  output word_t o_mem_data,
  output logic  o_mem_we
);

  core_state_e state;
  reg_addr_t rd, rs1, rs2;
  word_t imm, rs1_data, rs2_data, alu_b, alu_result, pc_plus4, wb_data;
  alu_op_e alu_op;
  wb_sel_e wb_sel;
  logic use_imm, rd_we, is_store, is_branch, is_jal, is_jalr, rf_we;

  rv_decode rv_decode_inst (
    .CLK         (CLK),
    .RST_N       (RST_N),
    .i_state     (state),
    .i_insn      (i_imem_data),
    .o_rd        (rd),
    .o_rs1       (rs1),
    .o_rs2       (rs2),
    .o_imm       (imm),
    .o_alu_op    (alu_op),
    .o_use_imm   (use_imm),
    .o_wb_sel    (wb_sel),
    .o_rd_we     (rd_we),
    .o_is_store  (is_store),
    .o_is_branch (is_branch),
    .o_is_jal    (is_jal),
    .o_is_jalr   (is_jalr)
  );

  assign alu_b = use_imm ? imm : rs2_data;

  rv_alu rv_alu_inst (
    .CLK      (CLK),
    .RST_N    (RST_N),
    .i_op     (alu_op),
    .i_a      (rs1_data),
    .i_b      (alu_b),
    .o_result (alu_result)
  );

  // writeback source
  always_comb begin
    case (wb_sel)
      WB_IMM:  wb_data = imm;
      WB_MEM:  wb_data = i_mem_data;
      WB_PC4:  wb_data = pc_plus4;
      default: wb_data = alu_result;
    endcase
  end

  assign rf_we = rd_we && (state == ST_WRITEBACK);

  rv_regfile rv_regfile_inst (
    .CLK        (CLK),
    .RST_N      (RST_N),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .i_rd       (rd),
    .i_we       (rf_we),
    .i_wdata    (wb_data),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  // branch condition is bit 0 of the compare result
  rv_sequencer rv_sequencer_inst (
    .CLK         (CLK),
    .RST_N       (RST_N),
    .i_is_branch (is_branch),
    .i_is_jal    (is_jal),
    .i_is_jalr   (is_jalr),
    .i_taken     (alu_result[0]),
    .i_rs1_data  (rs1_data),
    .i_imm       (imm),
    .o_state     (state),
    .o_pc        (),
    .o_pc_plus4  (pc_plus4),
    .o_imem_addr (o_imem_addr)
  );

  // data memory port
  assign o_mem_addr = alu_result;
  assign o_mem_data = rs2_data;
  assign o_mem_we   = is_store && (state == ST_MEMORY);

endmodule

// ==== test/tb_core_mem.sv ====
`timescale 1ns/1ps

module tb_core_mem import rv_core_pkg::*; (
  input  logic  CLK,
  input  word_t i_imem_addr,
  output word_t o_imem_data,
  input  word_t i_mem_addr,
  input  word_t i_mem_data,
  input  logic  i_mem_we,
  output word_t o_mem_data
);

  word_t imem [256];
  word_t dmem [256];

  // both ports register read data from the address before the edge
  always @(posedge CLK) begin
    o_imem_data <= imem[i_imem_addr[7:0]];
    o_mem_data  <= dmem[i_mem_addr[9:2]];
    if (i_mem_we) begin
      dmem[i_mem_addr[9:2]] <= i_mem_data;
    end
  end

  function automatic word_t fill_word(input int idx);
    return 32'hd00d_0000 | idx;
  endfunction

  // opcode 0 in the unused imem words decodes as a no-op
  task automatic clear_all();
    for (int i = 0; i < 256; i++) begin
      imem[i] = word_t'(i) << 7;
      dmem[i] = fill_word(i);
    end
  endtask

  task automatic write_insn(input int idx, input word_t insn);
    imem[idx] = insn;
  endtask

  function automatic word_t read_word(input word_t byte_addr);
    return dmem[byte_addr[9:2]];
  endfunction

  function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] f3,
                                   input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                   input logic [2:0] f3, input reg_addr_t rd,
                                   input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  // word store only
  function automatic word_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                   input reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic word_t b_type(input logic [12:0] imm, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic word_t u_type(input logic [19:0] imm, input reg_addr_t rd);
    return {imm, rd, OPC_LUI};
  endfunction

  function automatic word_t j_type(input logic [20:0] imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  initial begin
    o_imem_data = '0;
    o_mem_data  = '0;
    clear_all();
  end

endmodule

// ==== test/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core import rv_core_pkg::*; ();

  localparam int CLK_PERIOD = 100;
  localparam int PROG_MAX   = 128;
  localparam int NUM_TESTS  = 6;
  localparam int SLOT_BASE  = 32'h100;
  // reset, longest program and settling wait per test
  localparam int WATCHDOG_CYCLES = NUM_TESTS * ((PROG_MAX + 2) * 5 + 40);

  logic  CLK;
  logic  RST_N;
  word_t imem_addr, imem_data, mem_addr, mem_wdata, mem_rdata;
  logic  mem_we;

  integer seed;
  int     n_checks;
  int     n_errors;
  int     n_exec;
  word_t  prog[$];
  int     exp_slot[$];
  word_t  exp_val[$];

  rv_core_top rv_core_top_inst (
    .CLK         (CLK),
    .RST_N       (RST_N),
    .i_imem_data (imem_data),
    .i_mem_data  (mem_rdata),
    .o_imem_addr (imem_addr),
    .o_mem_addr  (mem_addr),
    .o_mem_data  (mem_wdata),
    .o_mem_we    (mem_we)
  );

  tb_core_mem mem_inst (
    .CLK         (CLK),
    .i_imem_addr (imem_addr),
    .o_imem_data (imem_data),
    .i_mem_addr  (mem_addr),
    .i_mem_data  (mem_wdata),
    .i_mem_we    (mem_we),
    .o_mem_data  (mem_rdata)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("Error: %s expected %h actual %h", name, expected, actual);
    end
  endtask

  function automatic word_t shift_right_arith(input word_t value, input logic [4:0] amount);
    word_t result;
    result = value;
    for (int i = 0; i < amount; i++) begin
      result = {result[31], result[31:1]};
    end
    return result;
  endfunction

  function automatic logic [2:0] kind_funct3(input int kind);
    case (kind)
      0:       return 3'b000;
      1:       return 3'b001;
      2:       return 3'b100;
      3:       return 3'b101;
      4:       return 3'b110;
      default: return 3'b111;
    endcase
  endfunction

  function automatic logic taken_by_rule(input logic [2:0] f3, input word_t x, input word_t y);
    case (f3)
      3'b000:  return x == y;
      3'b001:  return x != y;
      3'b100:  return $signed(x) < $signed(y);
      3'b101:  return $signed(x) >= $signed(y);
      3'b110:  return x < y;
      default: return x >= y;
    endcase
  endfunction

  task automatic new_program();
    prog.delete();
    exp_slot.delete();
    exp_val.delete();
    n_exec = 0;
  endtask

  task automatic emit(input word_t insn);
    prog.push_back(insn);
    n_exec++;
  endtask

  // addi sign extends, so the lui part is rounded up
  task automatic load_const(input reg_addr_t rd, input word_t value);
    word_t upper;
    upper = value + 32'h800;
    emit(mem_inst.u_type(upper[31:12], rd));
    emit(mem_inst.i_type(value[11:0], rd, 3'b000, rd, OPC_OP_IMM));
  endtask

  task automatic expect_slot(input int slot, input word_t expected);
    exp_slot.push_back(slot);
    exp_val.push_back(expected);
  endtask

  task automatic store_slot(input reg_addr_t rs2, input int slot, input word_t expected);
    word_t addr;
    addr = SLOT_BASE + slot * 4;
    emit(mem_inst.s_type(addr[11:0], rs2, 5'd0));
    expect_slot(slot, expected);
  endtask

  // x3 = x1 op x2
  task automatic reg_op(input logic [6:0] f7, input logic [2:0] f3, input int slot,
                        input word_t expected);
    emit(mem_inst.r_type(f7, 5'd2, 5'd1, f3, 5'd3));
    store_slot(5'd3, slot, expected);
  endtask

  // x3 = x1 op imm
  task automatic imm_op(input logic [11:0] imm, input logic [2:0] f3, input int slot,
                        input word_t expected);
    emit(mem_inst.i_type(imm, 5'd1, f3, 5'd3, OPC_OP_IMM));
    store_slot(5'd3, slot, expected);
  endtask

  task automatic start_program();
    emit(mem_inst.j_type(21'd0, 5'd0));
    @(posedge CLK);
    RST_N <= 1'b0;
    @(negedge CLK);
    mem_inst.clear_all();
    if (prog.size() > PROG_MAX) begin
      n_errors++;
      $display("program of %0d instructions does not fit the instruction memory",
               prog.size());
    end
    foreach (prog[i]) begin
      mem_inst.write_insn(i, prog[i]);
    end
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    check_value("reset store strobe", 32'd0, {31'd0, mem_we});
    check_value("reset fetch address", 32'd0, imem_addr);
    @(posedge CLK);
    RST_N <= 1'b1;
  endtask

  task automatic finish_program(input string name);
    word_t actual;
    string label;
    repeat ((n_exec + 1) * 5) @(posedge CLK);
    @(negedge CLK);
    foreach (exp_slot[i]) begin
      actual = mem_inst.read_word(SLOT_BASE + exp_slot[i] * 4);
      label  = $sformatf("%s slot %0d", name, exp_slot[i]);
      check_value(label, exp_val[i], actual);
    end
  endtask

  task automatic reset_and_first_store();
    new_program();
    emit(mem_inst.i_type(12'h055, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
    emit(mem_inst.i_type(12'h033, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
    store_slot(5'd1, 0, 32'h55);
    start_program();
    // the store is the third instruction
    // so its MEMORY cycle is cycle 14 after release
    for (int j = 0; j < 15; j++) begin
      @(negedge CLK);
      if (j == 1) begin
        check_value("reset first fetch address", 32'd0, imem_addr);
      end
      check_value("reset store strobe", (j == 14) ? 32'd1 : 32'd0, {31'd0, mem_we});
    end
    finish_program("reset");
  endtask

  task automatic register_arith();
    word_t a, b;
    a = $random(seed);
    b = $random(seed);
    new_program();
    load_const(5'd1, a);
    load_const(5'd2, b);
    reg_op(7'h00, 3'b000, 0, a + b);
    reg_op(7'h20, 3'b000, 1, a - b);
    reg_op(7'h00, 3'b010, 2, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
    reg_op(7'h00, 3'b011, 3, (a < b) ? 32'd1 : 32'd0);
    reg_op(7'h00, 3'b100, 4, a ^ b);
    reg_op(7'h00, 3'b110, 5, a | b);
    reg_op(7'h00, 3'b111, 6, a & b);
    start_program();
    finish_program("arith");
  endtask

  task automatic shifts_and_imm_forms();
    word_t a, b, imm_x;
    logic [4:0] sh;
    logic [11:0] imm;
    a     = $random(seed) | 32'h8000_0000;
    b     = $random(seed);
    sh    = $random(seed);
    imm   = $random(seed);
    imm_x = {{20{imm[11]}}, imm};
    new_program();
    load_const(5'd1, a);
    load_const(5'd2, b);
    imm_op({7'h00, sh}, 3'b001, 0, a << sh);
    imm_op({7'h00, sh}, 3'b101, 1, a >> sh);
    imm_op({7'h20, sh}, 3'b101, 2, shift_right_arith(a, sh));
    reg_op(7'h00, 3'b001, 3, a << b[4:0]);
    reg_op(7'h00, 3'b101, 4, a >> b[4:0]);
    reg_op(7'h20, 3'b101, 5, shift_right_arith(a, b[4:0]));
    imm_op(imm, 3'b010, 6, ($signed(a) < $signed(imm_x)) ? 32'd1 : 32'd0);
    imm_op(imm, 3'b011, 7, (a < imm_x) ? 32'd1 : 32'd0);
    imm_op(imm, 3'b100, 8, a ^ imm_x);
    imm_op(imm, 3'b110, 9, a | imm_x);
    imm_op(imm, 3'b111, 10, a & imm_x);
    // writes to x0 are lost
    emit(mem_inst.i_type(12'h123, 5'd1, 3'b000, 5'd0, OPC_OP_IMM));
    emit(mem_inst.r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));
    store_slot(5'd0, 11, 32'd0);
    start_program();
    finish_program("shifts");
  endtask

  task automatic load_store_round_trip();
    word_t v;
    v = $random(seed);
    new_program();
    load_const(5'd1, v);
    load_const(5'd5, SLOT_BASE - 16);
    emit(mem_inst.s_type(12'd16, 5'd1, 5'd5));
    expect_slot(0, v);
    emit(mem_inst.i_type(12'd16, 5'd5, 3'b010, 5'd2, OPC_LOAD));
    store_slot(5'd2, 1, v);
    start_program();
    finish_program("load store");
  endtask

  task automatic branch_outcomes();
    word_t a, b, x, y, mark_taken, mark_fall;
    logic [2:0] f3;
    logic taken;
    int slot;
    a    = $random(seed) | 32'h8000_0000;
    b    = $random(seed) & 32'h7fff_ffff;
    slot = 0;
    new_program();
    for (int k = 0; k < 6; k++) begin
      f3 = kind_funct3(k);
      for (int c = 0; c < 2; c++) begin
        // equal pair for BEQ and BNE
        // swapped pair for the ordered compares
        if (k < 2) begin
          x = a;
          y = (c == 0) ? a : b;
        end else begin
          x = (c == 0) ? a : b;
          y = (c == 0) ? b : a;
        end
        taken      = taken_by_rule(f3, x, y);
        mark_taken = 32'h300 + slot;
        mark_fall  = 32'h600 + slot;
        load_const(5'd1, x);
        load_const(5'd2, y);
        emit(mem_inst.b_type(13'd12, 5'd2, 5'd1, f3));
        emit(mem_inst.i_type(mark_fall[11:0], 5'd0, 3'b000, 5'd3, OPC_OP_IMM));
        emit(mem_inst.j_type(21'd8, 5'd0));
        emit(mem_inst.i_type(mark_taken[11:0], 5'd0, 3'b000, 5'd3, OPC_OP_IMM));
        store_slot(5'd3, slot, taken ? mark_taken : mark_fall);
        n_exec -= taken ? 2 : 1;
        slot++;
      end
    end
    start_program();
    finish_program("branch");
  endtask

  task automatic jump_links();
    word_t jal_pc, jalr_pc, target, base;
    new_program();
    jal_pc = prog.size() * 4;
    emit(mem_inst.j_type(21'd12, 5'd5));
    // skipped path leaves its slot at the fill value
    emit(mem_inst.i_type(12'h0bd, 5'd0, 3'b000, 5'd7, OPC_OP_IMM));
    store_slot(5'd7, 2, mem_inst.fill_word((SLOT_BASE >> 2) + 2));
    emit(mem_inst.i_type(12'h111, 5'd0, 3'b000, 5'd6, OPC_OP_IMM));
    store_slot(5'd6, 0, 32'h111);
    store_slot(5'd5, 1, jal_pc + 4);
    jalr_pc = (prog.size() + 1) * 4;
    target  = (prog.size() + 4) * 4;
    // odd sum checks that bit 0 of the target is cleared
    base    = target - 3;
    emit(mem_inst.i_type(base[11:0], 5'd0, 3'b000, 5'd8, OPC_OP_IMM));
    emit(mem_inst.i_type(12'd4, 5'd8, 3'b000, 5'd9, OPC_JALR));
    emit(mem_inst.i_type(12'h0be, 5'd0, 3'b000, 5'd7, OPC_OP_IMM));
    store_slot(5'd7, 3, mem_inst.fill_word((SLOT_BASE >> 2) + 3));
    emit(mem_inst.i_type(12'h222, 5'd0, 3'b000, 5'd6, OPC_OP_IMM));
    store_slot(5'd6, 4, 32'h222);
    store_slot(5'd9, 5, jalr_pc + 4);
    n_exec -= 4;
    start_program();
    finish_program("jump");
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    seed     = 32'h5e35;
    n_checks = 0;
    n_errors = 0;
    RST_N    = 1'b0;
    reset_and_first_store();
    register_arith();
    shifts_and_imm_forms();
    load_store_round_trip();
    branch_outcomes();
    jump_links();
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
source/rv_core_pkg.sv
source/rv_decode.sv
source/rv_alu.sv
source/rv_regfile.sv
source/rv_sequencer.sv
source/rv_core_top.sv
test/tb_core_mem.sv
test/tb_rv_core.sv
